// File: source/percWeightPkg.sv
package percWeightPkg;

	// Q15 fraction, scratch address and subframe select
	typedef logic signed [15:0] q15;
	typedef logic [5:0] memAddr;
	typedef logic subframeIdx;

	localparam int Q15_MAX = 32767;
	localparam int Q15_MIN = -32768;
	localparam int MEM_DEPTH = 64;

	////////////////////
	// Scratch memory map
	localparam int RC_BASE = 0;
	localparam int LSF_INT_BASE = 8;
	localparam int LSF_NEW_BASE = 24;
	localparam int GAMMA1_BASE = 40;
	localparam int GAMMA2_BASE = 42;
	localparam int LSF_COUNT = 10;

	////////////////////
	// LAR segments and offsets of the linear pieces
	localparam int LAR_SEG1 = 20480;
	localparam int LAR_SEG2 = 30720;
	localparam int LAR_OFF1 = 10240;
	localparam int LAR_OFF2 = 102400;

	// Hysteresis thresholds
	localparam int TILT_LAR1 = -14000;
	localparam int TILT_LAR2 = 5000;
	localparam int FLAT_LAR1 = -12000;
	localparam int FLAT_LAR2 = 3500;

	// Weighting factors
	localparam int GAMMA1_FLAT = 32113;
	localparam int GAMMA1_TILT = 30802;
	localparam int GAMMA2_FLAT = 19661;
	localparam int GAMMA2_MIN = 13107;
	localparam int GAMMA2_MAX = 22938;

	typedef enum logic [2:0] {IDLE, READ_RC, READ_LSF, DRAIN, WRITE, DONE} seqState;
	typedef enum logic {FLAT, TILTED} flatState;

endpackage

// File: source/scratchMem.sv
`timescale 1ns/1ps

module scratchMem
(
	input  logic clk,
	input  logic hostWrite,
	input  percWeightPkg::memAddr hostAddr,
	input  percWeightPkg::q15 hostWriteData,
	input  percWeightPkg::memAddr hostReadAddr,
	output percWeightPkg::q15 hostReadData,
	input  logic engineWrite,
	input  percWeightPkg::memAddr engineWriteAddr,
	input  percWeightPkg::q15 engineWriteData,
	input  percWeightPkg::memAddr engineReadAddr,
	output percWeightPkg::q15 engineReadData
);

	percWeightPkg::q15 mem [0:percWeightPkg::MEM_DEPTH-1];

	// Host loads operands while idle, engine writes results while busy
	always_ff @(posedge clk)
	begin
		if (hostWrite)
			mem[hostAddr] <= hostWriteData;
		if (engineWrite)
			mem[engineWriteAddr] <= engineWriteData;
	end

	// Both read ports return data one cycle after the address
	always_ff @(posedge clk)
	begin
		hostReadData <= mem[hostReadAddr];
		engineReadData <= mem[engineReadAddr];
	end

endmodule

// File: source/larStage.sv
`timescale 1ns/1ps

module larStage
(
	input  logic clk,
	input  logic rst,
	input  logic rcValid,
	input  percWeightPkg::q15 rc0,
	input  percWeightPkg::q15 rc1,
	output percWeightPkg::q15 lar1,
	output percWeightPkg::q15 lar2,
	output logic larValid
);

	// Three linear pieces on |rc| with the sign restored afterwards
	function automatic percWeightPkg::q15 larOf(input percWeightPkg::q15 rc);
		logic [15:0] a;
		logic [17:0] mag;
		a = rc[15] ? 16'(-rc) : 16'(rc);
		if (a < percWeightPkg::LAR_SEG1)
			mag = 18'(a) >> 1;
		else if (a < percWeightPkg::LAR_SEG2)
			mag = 18'(a) - 18'(percWeightPkg::LAR_OFF1);
		else
			mag = (18'(a) << 2) - 18'(percWeightPkg::LAR_OFF2);
		// Largest magnitude is 28672 and fits in Q15
		return rc[15] ? -percWeightPkg::q15'(mag[15:0]) : percWeightPkg::q15'(mag[15:0]);
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
			larValid <= 1'b0;
		else
			larValid <= rcValid;
	end

	always_ff @(posedge clk)
	begin
		if (rcValid)
		begin
			lar1 <= larOf(rc0);
			lar2 <= larOf(rc1);
		end
	end

endmodule

// File: source/flatnessDecide.sv
`timescale 1ns/1ps

module flatnessDecide
(
	input  logic clk,
	input  logic rst,
	input  logic larValid,
	input  percWeightPkg::q15 lar1,
	input  percWeightPkg::q15 lar2,
	output percWeightPkg::q15 gamma1,
	output logic flat,
	output logic decideValid
);

	percWeightPkg::flatState state;
	percWeightPkg::flatState nextState;

	////////////////////
	// Hysteresis between flat and tilted spectrum
	always_comb
	begin
		nextState = state;
		case (state)
			percWeightPkg::FLAT:
			begin
				if (lar1 < percWeightPkg::TILT_LAR1 && lar2 > percWeightPkg::TILT_LAR2)
					nextState = percWeightPkg::TILTED;
			end
			percWeightPkg::TILTED:
			begin
				if (lar1 > percWeightPkg::FLAT_LAR1 || lar2 < percWeightPkg::FLAT_LAR2)
					nextState = percWeightPkg::FLAT;
			end
			default:
				nextState = percWeightPkg::FLAT;
		endcase
	end

	// State carries over between subframes and frames
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= percWeightPkg::FLAT;
			decideValid <= 1'b0;
		end
		else
		begin
			decideValid <= larValid;
			if (larValid)
				state <= nextState;
		end
	end

	always_ff @(posedge clk)
	begin
		if (larValid)
			gamma1 <= (nextState == percWeightPkg::TILTED)
				? percWeightPkg::q15'(percWeightPkg::GAMMA1_TILT)
				: percWeightPkg::q15'(percWeightPkg::GAMMA1_FLAT);
	end

	assign flat = state == percWeightPkg::FLAT;

endmodule

// File: source/lsfMinDistance.sv
`timescale 1ns/1ps

module lsfMinDistance
(
	input  logic clk,
	input  logic rst,
	input  logic lsfValid,
	input  logic lsfLast,
	input  percWeightPkg::q15 lsf,
	output percWeightPkg::q15 dMin,
	output logic dMinValid
);

	percWeightPkg::q15 prevLsf;
	logic havePrev;
	percWeightPkg::q15 runMin;
	logic signed [16:0] diffWide;
	percWeightPkg::q15 diff;
	percWeightPkg::q15 candidate;

	// Saturated difference to the previous word
	always_comb
	begin
		diffWide = 17'(lsf) - 17'(prevLsf);
		if (diffWide > percWeightPkg::Q15_MAX)
			diff = percWeightPkg::q15'(percWeightPkg::Q15_MAX);
		else if (diffWide < percWeightPkg::Q15_MIN)
			diff = percWeightPkg::q15'(percWeightPkg::Q15_MIN);
		else
			diff = percWeightPkg::q15'(diffWide);
		candidate = (diff < runMin) ? diff : runMin;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			havePrev <= 1'b0;
			runMin <= percWeightPkg::q15'(percWeightPkg::Q15_MAX);
			dMinValid <= 1'b0;
		end
		else
		begin
			dMinValid <= lsfValid && lsfLast;
			if (lsfValid)
			begin
				havePrev <= !lsfLast;
				// Fresh minimum for the next set
				if (lsfLast)
					runMin <= percWeightPkg::q15'(percWeightPkg::Q15_MAX);
				else if (havePrev)
					runMin <= candidate;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (lsfValid)
		begin
			prevLsf <= lsf;
			if (lsfLast)
				dMin <= candidate;
		end
	end

endmodule

// File: source/gamma2Stage.sv
`timescale 1ns/1ps

module gamma2Stage
(
	input  logic clk,
	input  logic rst,
	input  logic dMinValid,
	input  percWeightPkg::q15 dMin,
	input  logic flat,
	output percWeightPkg::q15 gamma2,
	output logic gamma2Valid
);

	logic signed [19:0] wide;

	// One minus six times the distance before the clamp
	always_comb
	begin
		wide = 20'(percWeightPkg::Q15_MAX) - 20'(dMin) * 20'sd6;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			gamma2Valid <= 1'b0;
		else
			gamma2Valid <= dMinValid;
	end

	always_ff @(posedge clk)
	begin
		if (dMinValid)
		begin
			if (flat)
				gamma2 <= percWeightPkg::q15'(percWeightPkg::GAMMA2_FLAT);
			else if (wide > percWeightPkg::GAMMA2_MAX)
				gamma2 <= percWeightPkg::q15'(percWeightPkg::GAMMA2_MAX);
			else if (wide < percWeightPkg::GAMMA2_MIN)
				gamma2 <= percWeightPkg::q15'(percWeightPkg::GAMMA2_MIN);
			else
				gamma2 <= percWeightPkg::q15'(wide);
		end
	end

endmodule

// File: source/percVarSequencer.sv
`timescale 1ns/1ps

module percVarSequencer
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  percWeightPkg::q15 engineReadData,
	output percWeightPkg::memAddr engineReadAddr,
	output logic engineWrite,
	output percWeightPkg::memAddr engineWriteAddr,
	output percWeightPkg::q15 engineWriteData,
	output logic rcValid,
	output percWeightPkg::q15 rc0,
	output percWeightPkg::q15 rc1,
	output logic lsfValid,
	output logic lsfLast,
	output percWeightPkg::q15 lsf,
	output logic busy,
	output logic done,
	input  percWeightPkg::q15 gamma1,
	input  logic decideValid,
	input  percWeightPkg::q15 gamma2,
	input  logic gamma2Valid
);

	percWeightPkg::seqState state;
	percWeightPkg::subframeIdx sf;
	logic [3:0] step;

	// Tags for the word now on engineReadData
	logic rc0Pend;
	logic rc1Pend;
	logic lsfPend;
	logic lsfLastPend;

	percWeightPkg::subframeIdx gamma1Idx;
	percWeightPkg::subframeIdx gamma2Idx;
	percWeightPkg::q15 gamma1Reg [0:1];
	percWeightPkg::q15 gamma2Reg [0:1];

	////////////////////
	// Frame FSM
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= percWeightPkg::IDLE;
			sf <= 1'b0;
			step <= '0;
		end
		else
		begin
			case (state)
				percWeightPkg::IDLE:
				begin
					if (start)
					begin
						state <= percWeightPkg::READ_RC;
						sf <= 1'b0;
						step <= '0;
					end
				end
				percWeightPkg::READ_RC:
				begin
					if (step[0])
					begin
						state <= percWeightPkg::READ_LSF;
						step <= '0;
					end
					else
						step <= step + 4'd1;
				end
				percWeightPkg::READ_LSF:
				begin
					if (step == 4'(percWeightPkg::LSF_COUNT - 1))
					begin
						step <= '0;
						// Subframe 1 reads overlap subframe 0 in the stages
						if (sf == 1'b0)
						begin
							state <= percWeightPkg::READ_RC;
							sf <= 1'b1;
						end
						else
							state <= percWeightPkg::DRAIN;
					end
					else
						step <= step + 4'd1;
				end
				percWeightPkg::DRAIN:
				begin
					if (gamma2Valid && gamma2Idx == 1'b1)
						state <= percWeightPkg::WRITE;
				end
				percWeightPkg::WRITE:
				begin
					if (step == 4'd3)
						state <= percWeightPkg::DONE;
					else
						step <= step + 4'd1;
				end
				percWeightPkg::DONE:
					state <= percWeightPkg::IDLE;
				default:
					state <= percWeightPkg::IDLE;
			endcase
		end
	end

	// Read tags follow the one-cycle memory latency
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rc0Pend <= 1'b0;
			rc1Pend <= 1'b0;
			lsfPend <= 1'b0;
			lsfLastPend <= 1'b0;
			rcValid <= 1'b0;
			lsfValid <= 1'b0;
			lsfLast <= 1'b0;
		end
		else
		begin
			rc0Pend <= (state == percWeightPkg::READ_RC) && !step[0];
			rc1Pend <= (state == percWeightPkg::READ_RC) && step[0];
			lsfPend <= state == percWeightPkg::READ_LSF;
			lsfLastPend <= (state == percWeightPkg::READ_LSF)
				&& (step == 4'(percWeightPkg::LSF_COUNT - 1));
			rcValid <= rc1Pend;
			lsfValid <= lsfPend;
			lsfLast <= lsfLastPend;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rc0Pend)
			rc0 <= engineReadData;
		if (rc1Pend)
			rc1 <= engineReadData;
		if (lsfPend)
			lsf <= engineReadData;
	end

	////////////////////
	// Result capture, in subframe order
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			gamma1Idx <= 1'b0;
			gamma2Idx <= 1'b0;
		end
		else if (state == percWeightPkg::IDLE && start)
		begin
			gamma1Idx <= 1'b0;
			gamma2Idx <= 1'b0;
		end
		else
		begin
			if (decideValid)
				gamma1Idx <= ~gamma1Idx;
			if (gamma2Valid)
				gamma2Idx <= ~gamma2Idx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (decideValid)
			gamma1Reg[gamma1Idx] <= gamma1;
		if (gamma2Valid)
			gamma2Reg[gamma2Idx] <= gamma2;
	end

	always_comb
	begin
		case (state)
			percWeightPkg::READ_RC:
				engineReadAddr = percWeightPkg::memAddr'(percWeightPkg::RC_BASE + 2 * sf + step[0]);
			percWeightPkg::READ_LSF:
				engineReadAddr = sf ? percWeightPkg::memAddr'(percWeightPkg::LSF_NEW_BASE + step)
					: percWeightPkg::memAddr'(percWeightPkg::LSF_INT_BASE + step);
			default:
				engineReadAddr = percWeightPkg::memAddr'(percWeightPkg::RC_BASE);
		endcase
	end

	// Write order is gamma1 of both subframes, then gamma2
	assign engineWrite = state == percWeightPkg::WRITE;
	assign engineWriteAddr = step[1]
		? percWeightPkg::memAddr'(percWeightPkg::GAMMA2_BASE + step[0])
		: percWeightPkg::memAddr'(percWeightPkg::GAMMA1_BASE + step[0]);
	assign engineWriteData = step[1] ? gamma2Reg[step[0]] : gamma1Reg[step[0]];
	assign busy = state != percWeightPkg::IDLE;
	assign done = state == percWeightPkg::DONE;

endmodule

// File: source/percWeightTop.sv
`timescale 1ns/1ps

module percWeightTop
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic hostWrite,
	input  percWeightPkg::memAddr hostAddr,
	input  percWeightPkg::q15 hostWriteData,
	input  percWeightPkg::memAddr hostReadAddr,
	output percWeightPkg::q15 hostReadData,
	output logic busy,
	output logic done
);

	percWeightPkg::memAddr engineReadAddr;
	percWeightPkg::memAddr engineWriteAddr;
	percWeightPkg::q15 engineReadData;
	percWeightPkg::q15 engineWriteData;
	logic engineWrite;

	logic rcValid;
	logic larValid;
	logic decideValid;
	logic lsfValid;
	logic lsfLast;
	logic dMinValid;
	logic gamma2Valid;
	logic flat;
	percWeightPkg::q15 rc0;
	percWeightPkg::q15 rc1;
	percWeightPkg::q15 lar1;
	percWeightPkg::q15 lar2;
	percWeightPkg::q15 gamma1;
	percWeightPkg::q15 lsf;
	percWeightPkg::q15 dMin;
	percWeightPkg::q15 gamma2;

	scratchMem memory
	(
		.clk(clk),
		.hostWrite(hostWrite),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostReadAddr(hostReadAddr),
		.hostReadData(hostReadData),
		.engineWrite(engineWrite),
		.engineWriteAddr(engineWriteAddr),
		.engineWriteData(engineWriteData),
		.engineReadAddr(engineReadAddr),
		.engineReadData(engineReadData)
	);

	percVarSequencer sequencer
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.engineReadData(engineReadData),
		.engineReadAddr(engineReadAddr),
		.engineWrite(engineWrite),
		.engineWriteAddr(engineWriteAddr),
		.engineWriteData(engineWriteData),
		.rcValid(rcValid),
		.rc0(rc0),
		.rc1(rc1),
		.lsfValid(lsfValid),
		.lsfLast(lsfLast),
		.lsf(lsf),
		.busy(busy),
		.done(done),
		.gamma1(gamma1),
		.decideValid(decideValid),
		.gamma2(gamma2),
		.gamma2Valid(gamma2Valid)
	);

	////////////////////
	// gamma1 path
	larStage lar
	(
		.clk(clk),
		.rst(rst),
		.rcValid(rcValid),
		.rc0(rc0),
		.rc1(rc1),
		.lar1(lar1),
		.lar2(lar2),
		.larValid(larValid)
	);

	flatnessDecide decide
	(
		.clk(clk),
		.rst(rst),
		.larValid(larValid),
		.lar1(lar1),
		.lar2(lar2),
		.gamma1(gamma1),
		.flat(flat),
		.decideValid(decideValid)
	);

	////////////////////
	// gamma2 path
	lsfMinDistance minDist
	(
		.clk(clk),
		.rst(rst),
		.lsfValid(lsfValid),
		.lsfLast(lsfLast),
		.lsf(lsf),
		.dMin(dMin),
		.dMinValid(dMinValid)
	);

	gamma2Stage gamma2Calc
	(
		.clk(clk),
		.rst(rst),
		.dMinValid(dMinValid),
		.dMin(dMin),
		.flat(flat),
		.gamma2(gamma2),
		.gamma2Valid(gamma2Valid)
	);

endmodule

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
	output logic clk
);

	// 8 ns period
	localparam realtime HALF_PERIOD = 4.0;

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

endmodule

// File: verification/percWeightTb.sv
`timescale 1ns/1ps

module percWeightTb;

	localparam int DIRECTED_FRAMES = 6;
	localparam int RANDOM_FRAMES = 40;
	localparam int CYCLES_PER_FRAME = 150;
	localparam int CYCLE_LIMIT = (DIRECTED_FRAMES + RANDOM_FRAMES) * CYCLES_PER_FRAME + 20;

	logic clk;
	logic rst;
	logic start;
	logic hostWrite;
	percWeightPkg::memAddr hostAddr;
	percWeightPkg::q15 hostWriteData;
	percWeightPkg::memAddr hostReadAddr;
	percWeightPkg::q15 hostReadData;
	logic busy;
	logic done;

	int errors;
	int checks;
	int cycles;
	int doneCount;
	int framesRun;
	logic inFrame;
	integer seed;

	// Operands of the current frame and the model's view of it
	int rcBuf [0:3];
	int lsfInt [0:9];
	int lsfNew [0:9];
	int expGamma1 [0:1];
	int expGamma2 [0:1];
	bit modelTilted;

	clockGen clocks
	(
		.clk(clk)
	);

	percWeightTop dut
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.hostWrite(hostWrite),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostReadAddr(hostReadAddr),
		.hostReadData(hostReadData),
		.busy(busy),
		.done(done)
	);

	task automatic checkValue(input string name, input int got, input int expected);
		checks++;
		assert (got == expected)
		else
		begin
			errors++;
			$display("error at %0t ns: %s got %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic reportProblem(input string what);
		errors++;
		$display("at %0t ns: %s", $time, what);
	endtask

	////////////////////
	// Reference model
	function automatic int refLar(input int rc);
		int a;
		int m;
		a = (rc < 0) ? -rc : rc;
		if (a < 20480)
			m = a / 2;
		else if (a < 30720)
			m = a - 10240;
		else
			m = 4 * a - 102400;
		return (rc < 0) ? -m : m;
	endfunction

	// Smallest saturated step between neighbouring LSFs
	function automatic int minGap(input bit useNew);
		int m;
		int d;
		m = 32767;
		for (int i = 1; i < 10; i++)
		begin
			d = useNew ? lsfNew[i] - lsfNew[i-1] : lsfInt[i] - lsfInt[i-1];
			if (d > 32767)
				d = 32767;
			if (d < -32768)
				d = -32768;
			if (d < m)
				m = d;
		end
		return m;
	endfunction

	task automatic computeExpected();
		int l1;
		int l2;
		int w;
		for (int sf = 0; sf < 2; sf++)
		begin
			l1 = refLar(rcBuf[2*sf]);
			l2 = refLar(rcBuf[2*sf+1]);
			if (!modelTilted && l1 < -14000 && l2 > 5000)
				modelTilted = 1'b1;
			else if (modelTilted && (l1 > -12000 || l2 < 3500))
				modelTilted = 1'b0;
			expGamma1[sf] = modelTilted ? 30802 : 32113;
			w = 32767 - 6 * minGap(sf == 1);
			if (w > 22938)
				w = 22938;
			if (w < 13107)
				w = 13107;
			expGamma2[sf] = modelTilted ? w : 19661;
		end
	endtask

	////////////////////
	// Host port access
	task automatic writeWord(input int addr, input int value);
		@(posedge clk);
		#1;
		hostWrite = 1'b1;
		hostAddr = percWeightPkg::memAddr'(addr);
		hostWriteData = percWeightPkg::q15'(value);
	endtask

	task automatic readWord(input int addr, output int value);
		@(posedge clk);
		#1 hostReadAddr = percWeightPkg::memAddr'(addr);
		@(posedge clk);
		@(negedge clk);
		value = hostReadData;
	endtask

	task automatic loadFrame();
		for (int i = 0; i < 4; i++)
			writeWord(percWeightPkg::RC_BASE + i, rcBuf[i]);
		for (int i = 0; i < 10; i++)
			writeWord(percWeightPkg::LSF_INT_BASE + i, lsfInt[i]);
		for (int i = 0; i < 10; i++)
			writeWord(percWeightPkg::LSF_NEW_BASE + i, lsfNew[i]);
		// Stale results must not pass for new ones
		for (int i = 0; i < 4; i++)
			writeWord(percWeightPkg::GAMMA1_BASE + i, 16'hA500 ^ (percWeightPkg::GAMMA1_BASE + i));
		@(posedge clk);
		#1 hostWrite = 1'b0;
	endtask

	task automatic setRc(input int sf, input int r0, input int r1);
		rcBuf[2*sf] = r0;
		rcBuf[2*sf+1] = r1;
	endtask

	task automatic fillLsf(input int sf, input int first, input int stepSize);
		for (int i = 0; i < 10; i++)
		begin
			if (sf == 1)
				lsfNew[i] = first + i * stepSize;
			else
				lsfInt[i] = first + i * stepSize;
		end
	endtask

	function automatic int randRange(input int lo, input int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	// Load, start, wait for done, then compare the four results
	task automatic runFrame(input bit extraStart);
		int got;
		computeExpected();
		loadFrame();
		@(posedge clk);
		#1 start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
		if (extraStart)
		begin
			repeat (4) @(posedge clk);
			#1 start = 1'b1;
			@(posedge clk);
			#1 start = 1'b0;
		end
		@(negedge clk);
		while (!done)
			@(negedge clk);
		framesRun++;
		@(negedge clk);
		checkValue("done count", doneCount, framesRun);
		for (int sf = 0; sf < 2; sf++)
		begin
			readWord(percWeightPkg::GAMMA1_BASE + sf, got);
			checkValue($sformatf("gamma1[%0d]", sf), got, expGamma1[sf]);
			readWord(percWeightPkg::GAMMA2_BASE + sf, got);
			checkValue($sformatf("gamma2[%0d]", sf), got, expGamma2[sf]);
		end
	endtask

	task automatic randomFrame();
		for (int sf = 0; sf < 2; sf++)
		begin
			// Half the subframes lean towards a tilted spectrum
			if (randRange(0, 1) == 1)
				setRc(sf, randRange(-32768, -20000), randRange(6000, 32767));
			else
				setRc(sf, randRange(-32768, 32767), randRange(-32768, 32767));
		end
		lsfInt[0] = randRange(0, 2000);
		lsfNew[0] = randRange(0, 2000);
		for (int i = 1; i < 10; i++)
		begin
			lsfInt[i] = lsfInt[i-1] + randRange(-200, 3000);
			lsfNew[i] = lsfNew[i-1] + randRange(-200, 3000);
		end
		runFrame(1'b0);
	endtask

	////////////////////
	// Control protocol monitor
	always @(negedge clk)
	begin
		if (rst)
			inFrame = 1'b0;
		else
		begin
			checkValue("busy", busy, inFrame);
			if (done)
			begin
				assert (inFrame)
				else
					reportProblem("done pulsed while no frame was in progress");
				doneCount++;
				inFrame = 1'b0;
			end
			else if (start && !inFrame)
				inFrame = 1'b1;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			reportProblem("run did not finish within the cycle limit");
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("sim failed");
			$finish;
		end
	end

	initial
	begin
		seed = 73;
		errors = 0;
		checks = 0;
		cycles = 0;
		doneCount = 0;
		framesRun = 0;
		inFrame = 1'b0;
		modelTilted = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		hostWrite = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		hostReadAddr = '0;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		@(negedge clk);
		checkValue("busy", busy, 0);
		checkValue("done", done, 0);

		// Small coefficients stay flat
		setRc(0, 1200, -900);
		setRc(1, -3000, 2500);
		fillLsf(0, 1500, 2800);
		fillLsf(1, 1200, 3000);
		runFrame(1'b0);

		// Tilted with gamma2 at both clamp limits
		setRc(0, -30000, 12000);
		setRc(1, -31000, 25000);
		fillLsf(0, 2000, 1000);
		fillLsf(1, 1000, 3300);
		runFrame(1'b0);

		// Tilted with gamma2 inside the range and a second start ignored
		setRc(0, -29000, 16000);
		setRc(1, -30000, 20000);
		fillLsf(0, 1000, 2000);
		fillLsf(1, 3000, 2000);
		runFrame(1'b1);

		// Between the thresholds after tilted
		setRc(0, -23240, 8000);
		setRc(1, -22740, 7200);
		fillLsf(0, 500, 1500);
		fillLsf(1, 800, 2500);
		runFrame(1'b0);

		// Back to flat
		setRc(0, -23240, 2000);
		setRc(1, 400, 400);
		fillLsf(0, 900, 2100);
		fillLsf(1, 700, 2900);
		runFrame(1'b0);

		// Between the thresholds after flat
		setRc(0, -23240, 8000);
		setRc(1, -31000, 8000);
		fillLsf(0, 1000, 2000);
		fillLsf(1, 400, 1200);
		runFrame(1'b0);

		for (int n = 0; n < RANDOM_FRAMES; n++)
			randomFrame();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: all.f
source/percWeightPkg.sv
source/scratchMem.sv
source/larStage.sv
source/flatnessDecide.sv
source/lsfMinDistance.sv
source/gamma2Stage.sv
source/percVarSequencer.sv
source/percWeightTop.sv
verification/clockGen.sv
verification/percWeightTb.sv
